// ==== compile.f ====
serv_pc_pkg.sv
ser_add.sv
shift_reg.sv
serv_ctrl.sv
serv_pc_seq.sv
serv_pc_top.sv
tb_serv_pc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PC unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
   --top-module tb_serv_pc -o tb_serv_pc > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status, see build.log"
   cat build.log
   exit 1
fi

./obj_dir/tb_serv_pc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

grep -qF '*** PASSED ***' sim.log
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation did not pass, see sim.log"
   exit 1
fi

echo "Simulation passed"
exit 0

// ==== tb_serv_pc.sv ====
`timescale 1ns/1ns

module tb_serv_pc import serv_pc_pkg::*; ();

   localparam logic [XLEN-1:0] RESET_PC = 32'd8;
   localparam int READY_TIMEOUT = 100;
   localparam int RSP_TIMEOUT   = 100;
   localparam int FETCH_TIMEOUT = 100;
   localparam int CYC_RISE      = 34; // Cycles from accept to fetch start.

   logic            clk;
   logic            i_rst;
   logic            i_cmd_valid;
   ctrl_cmd_t       i_cmd;
   logic            o_cmd_ready;
   logic            o_rsp_valid;
   ctrl_rsp_t       o_rsp;
   logic            o_ibus_cyc;
   logic [XLEN-1:0] o_ibus_adr;
   logic            i_ibus_ack;
   logic            o_bad_pc;

   logic [XLEN-1:0] pc_model; // Reference PC.
   int              errors;
   int              checks;

   serv_pc_top #(
      .RESET_PC (RESET_PC)
   ) dut0 (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_cmd_valid (i_cmd_valid),
      .i_cmd       (i_cmd),
      .o_cmd_ready (o_cmd_ready),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_ibus_adr  (o_ibus_adr),
      .i_ibus_ack  (i_ibus_ack),
      .o_bad_pc    (o_bad_pc)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAIL %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAIL %s: got %h expected %h", name, got, exp);
      end
   endtask

   // Bus side of one fetch. Starts at the first negedge after accept.
   task automatic serve_fetch(input logic [31:0] exp_adr);
      int          rise_cycle;
      int          delay;
      logic [31:0] adr;
      rise_cycle = 1;
      while (!o_ibus_cyc && rise_cycle < FETCH_TIMEOUT) begin
         @(negedge clk);
         rise_cycle++;
      end
      assert (o_ibus_cyc) else begin
         errors++;
         $display("Timed out waiting for an instruction fetch to start.");
      end
      if (o_ibus_cyc) begin
         check_value("o_ibus_cyc rise cycle", rise_cycle, CYC_RISE);
         check_value("o_ibus_adr", o_ibus_adr, exp_adr);
         adr   = o_ibus_adr;
         delay = $urandom % 4;
         repeat (delay) begin
            @(negedge clk);
            check_bit("o_ibus_cyc", o_ibus_cyc, 1'b1); // Held until ack.
            check_value("o_ibus_adr", o_ibus_adr, adr);
         end
         i_ibus_ack = 1'b1;
         @(negedge clk);
         i_ibus_ack = 1'b0;
         check_bit("o_ibus_cyc", o_ibus_cyc, 1'b0);
         check_value("o_ibus_adr", o_ibus_adr, adr);
      end
   endtask

   // Serial target on o_bad_pc, bit k in window cycle 1+k.
   task automatic collect_bad_pc(input logic [31:0] exp_target);
      logic [31:0] bits;
      int          k;
      bits = '0;
      for (k = 0; k < XLEN; k++) begin
         if (k > 0) begin
            @(negedge clk);
         end
         bits[k] = o_bad_pc;
      end
      check_value("o_bad_pc", bits, exp_target);
   endtask

   task automatic wait_response(input logic [31:0] exp_rd, input logic exp_mis);
      int waited;
      waited = 0;
      while (!o_rsp_valid && waited < RSP_TIMEOUT) begin
         check_bit("o_cmd_ready", o_cmd_ready, 1'b0); // Busy.
         @(negedge clk);
         waited++;
      end
      assert (o_rsp_valid) else begin
         errors++;
         $display("Timed out waiting for the response pulse.");
      end
      if (o_rsp_valid) begin
         check_bit("o_cmd_ready", o_cmd_ready, 1'b1);
         check_value("o_rsp.rd", o_rsp.rd, exp_rd);
         check_bit("o_rsp.misalign", o_rsp.misalign, exp_mis);
      end
      i_cmd_valid = 1'b0;
   endtask

   task automatic send_cmd(input ctrl_op_e op, input logic [31:0] offset,
                           input logic [31:0] rs1, input logic [31:0] csr_pc,
                           input logic hold);
      logic [31:0] base;
      logic [31:0] sum;
      logic [31:0] target;
      logic [31:0] pc_next;
      logic [31:0] new_pc;
      logic [31:0] exp_rd;
      logic        exp_mis;
      int          waited;
      base    = (op == OP_JALR) ? rs1 : pc_model;
      sum     = base + offset;
      target  = sum & ~32'd1;
      pc_next = pc_model + 32'd4;
      exp_mis = sum[1];
      case (op)
         OP_TRAP:         new_pc = csr_pc & ~32'd1;
         OP_JAL, OP_JALR: new_pc = target;
         default:         new_pc = pc_next;
      endcase
      case (op)
         OP_LUI:   exp_rd = offset;
         OP_AUIPC: exp_rd = target;
         default:  exp_rd = pc_next; // Link value.
      endcase
      waited = 0;
      while (!o_cmd_ready && waited < READY_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      assert (o_cmd_ready) else begin
         errors++;
         $display("Timed out waiting for command ready.");
      end
      i_cmd.op     = op;
      i_cmd.offset = offset;
      i_cmd.rs1    = rs1;
      i_cmd.csr_pc = csr_pc;
      i_cmd_valid  = 1'b1;
      @(negedge clk);
      if (!hold) begin
         i_cmd_valid = 1'b0;
      end
      fork
         serve_fetch(new_pc);
         collect_bad_pc(target);
         wait_response(exp_rd, exp_mis);
      join
      pc_model = new_pc;
   endtask

   task automatic test_reset_step();
      repeat (4) send_cmd(OP_STEP, 32'h0, 32'h0, 32'h0, 1'b0); // 12, 16, 20, 24.
   endtask

   task automatic test_jal();
      send_cmd(OP_JAL, 32'h0000_0100, 32'h0, 32'h0, 1'b0);
      send_cmd(OP_JAL, 32'hffff_ffe0, 32'h0, 32'h0, 1'b0); // Backwards.
      send_cmd(OP_JAL, 32'h0000_0013, 32'h0, 32'h0, 1'b0);
      send_cmd(OP_JAL, 32'h0000_0006, 32'h0, 32'h0, 1'b0);
      send_cmd(OP_STEP, 32'h0, 32'h0, 32'h0, 1'b0);
   endtask

   task automatic test_jalr();
      send_cmd(OP_JALR, 32'h0000_0010, 32'h0000_4001, 32'h0, 1'b0);
      send_cmd(OP_JALR, 32'h0000_0002, 32'h0000_4001, 32'h0, 1'b0);
      send_cmd(OP_JALR, 32'h0000_0001, 32'hffff_ffff, 32'h0, 1'b0); // Wraps to 0.
      send_cmd(OP_JALR, 32'h0000_0008, 32'hffff_fffc, 32'h0, 1'b0);
      send_cmd(OP_JALR, 32'h0000_0001, 32'h7fff_ffff, 32'h0, 1'b0);
      send_cmd(OP_JALR, 32'hffff_f800, 32'h0001_0000, 32'h0, 1'b0);
   endtask

   task automatic test_lui_auipc();
      send_cmd(OP_LUI, 32'h1234_5000, 32'h0, 32'h0, 1'b0);
      send_cmd(OP_LUI, 32'hdead_beef, 32'h0, 32'h0, 1'b0);
      send_cmd(OP_AUIPC, 32'h0000_1000, 32'h0, 32'h0, 1'b0);
      send_cmd(OP_AUIPC, 32'hffff_f001, 32'h0, 32'h0, 1'b0);
   endtask

   task automatic test_trap();
      send_cmd(OP_TRAP, 32'h0, 32'h0, 32'h0000_0201, 1'b0);
      send_cmd(OP_STEP, 32'h0, 32'h0, 32'h0, 1'b0);
      send_cmd(OP_TRAP, 32'h0000_0042, 32'h0, 32'h8000_0101, 1'b0);
      send_cmd(OP_STEP, 32'h0, 32'h0, 32'h0, 1'b0);
   endtask

   // Valid stays high while the DUT is busy.
   task automatic test_hold_delay();
      send_cmd(OP_STEP, 32'h0, 32'h0, 32'h0, 1'b1);
      send_cmd(OP_JAL, 32'h0000_0204, 32'h0, 32'h0, 1'b1);
      send_cmd(OP_LUI, 32'hcafe_f00d, 32'h0, 32'h0, 1'b1);
      send_cmd(OP_JALR, 32'h0000_0003, 32'h0000_1000, 32'h0, 1'b1);
      send_cmd(OP_TRAP, 32'h0, 32'h0, 32'h0000_0400, 1'b1);
      send_cmd(OP_AUIPC, 32'h0000_0020, 32'h0, 32'h0, 1'b1);
      send_cmd(OP_STEP, 32'h0, 32'h0, 32'h0, 1'b1);
   endtask

   initial begin
      void'($urandom(32'h4a7a_f652));
      errors      = 0;
      checks      = 0;
      i_rst       = 1'b1;
      i_cmd_valid = 1'b0;
      i_cmd       = '0;
      i_ibus_ack  = 1'b0;
      pc_model    = RESET_PC;
      repeat (5) @(negedge clk);
      check_bit("o_cmd_ready", o_cmd_ready, 1'b0);
      check_bit("o_rsp_valid", o_rsp_valid, 1'b0);
      check_bit("o_ibus_cyc", o_ibus_cyc, 1'b0);
      check_value("o_ibus_adr", o_ibus_adr, RESET_PC);
      i_rst = 1'b0;
      @(negedge clk);
      check_bit("o_cmd_ready", o_cmd_ready, 1'b1);
      test_reset_step();
      test_jal();
      test_jalr();
      test_lui_auipc();
      test_trap();
      test_hold_delay();
      @(negedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== serv_pc_top.sv ====
`timescale 1ns/1ns

module serv_pc_top import serv_pc_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = 32'd8
) (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_cmd_valid,
   input  ctrl_cmd_t       i_cmd,
   output logic            o_cmd_ready,
   output logic            o_rsp_valid,
   output ctrl_rsp_t       o_rsp,
   output logic            o_ibus_cyc,
   output logic [XLEN-1:0] o_ibus_adr,
   input  logic            i_ibus_ack,
   output logic            o_bad_pc
);

   logic en;
   logic pc_en;
   logic cnt_done;
   logic jump;
   logic jalr;
   logic lui;
   logic auipc;
   logic trap;
   logic offset;
   logic rs1;
   logic csr_pc;
   logic rd;
   logic misalign;

   serv_pc_seq u_seq (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_cmd_valid (i_cmd_valid),
      .i_cmd       (i_cmd),
      .o_cmd_ready (o_cmd_ready),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .i_rd        (rd),
      .i_misalign  (misalign),
      .i_ibus_cyc  (o_ibus_cyc),
      .o_en        (en),
      .o_pc_en     (pc_en),
      .o_cnt_done  (cnt_done),
      .o_jump      (jump),
      .o_jalr      (jalr),
      .o_lui       (lui),
      .o_auipc     (auipc),
      .o_trap      (trap),
      .o_offset    (offset),
      .o_rs1       (rs1),
      .o_csr_pc    (csr_pc)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_en       (en),
      .i_pc_en    (pc_en),
      .i_cnt_done (cnt_done),
      .i_jump     (jump),
      .i_offset   (offset),
      .i_rs1      (rs1),
      .i_jalr     (jalr),
      .i_auipc    (auipc),
      .i_lui      (lui),
      .i_trap     (trap),
      .i_csr_pc   (csr_pc),
      .o_rd       (rd),
      .o_bad_pc   (o_bad_pc),
      .o_misalign (misalign),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack)
   );

endmodule

// ==== serv_pc_seq.sv ====
`timescale 1ns/1ns

module serv_pc_seq import serv_pc_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_cmd_valid,
   input  ctrl_cmd_t i_cmd,
   output logic      o_cmd_ready,
   output logic      o_rsp_valid,
   output ctrl_rsp_t o_rsp,
   input  logic      i_rd,
   input  logic      i_misalign,
   input  logic      i_ibus_cyc,
   output logic      o_en,
   output logic      o_pc_en,
   output logic      o_cnt_done,
   output logic      o_jump,
   output logic      o_jalr,
   output logic      o_lui,
   output logic      o_auipc,
   output logic      o_trap,
   output logic      o_offset,
   output logic      o_rs1,
   output logic      o_csr_pc
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_RUN,
      S_FETCH,
      S_RESP
   } state_e;

   state_e          state;
   logic [4:0]      cnt;
   logic            init_done;
   logic            cyc_r;
   logic            cyc_fall;
   logic            accept;
   logic            run;
   ctrl_op_e        op_q;
   logic [XLEN-1:0] rd_q;

   assign run      = (state == S_RUN);
   assign cyc_fall = cyc_r & ~i_ibus_cyc;
   assign accept   = i_cmd_valid & o_cmd_ready;

   assign o_rsp_valid  = (state == S_RESP) & cyc_fall;
   assign o_cmd_ready  = ((state == S_IDLE) & init_done) | o_rsp_valid;
   assign o_rsp.rd       = rd_q;
   assign o_rsp.misalign = i_misalign;

   assign o_en       = run;
   assign o_pc_en    = run;
   assign o_cnt_done = run & (cnt == 5'd31);
   assign o_jump     = run & ((op_q == OP_JAL) | (op_q == OP_JALR));
   assign o_jalr     = run & (op_q == OP_JALR);
   assign o_lui      = run & (op_q == OP_LUI);
   assign o_auipc    = run & (op_q == OP_AUIPC);
   assign o_trap     = run & (op_q == OP_TRAP);

   shift_reg #(.LEN(XLEN)) u_ser_offset (
      .clk (clk), .i_en (run), .i_d (1'b0), .i_load (accept),
      .i_load_d (i_cmd.offset), .o_q (o_offset), .o_par ()
   );

   shift_reg #(.LEN(XLEN)) u_ser_rs1 (
      .clk (clk), .i_en (run), .i_d (1'b0), .i_load (accept),
      .i_load_d (i_cmd.rs1), .o_q (o_rs1), .o_par ()
   );

   shift_reg #(.LEN(XLEN)) u_ser_csr_pc (
      .clk (clk), .i_en (run), .i_d (1'b0), .i_load (accept),
      .i_load_d (i_cmd.csr_pc), .o_q (o_csr_pc), .o_par ()
   );

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state     <= S_IDLE;
         cnt       <= 5'd0;
         init_done <= 1'b0;
         cyc_r     <= 1'b0;
      end else begin
         init_done <= 1'b1;
         cyc_r     <= i_ibus_cyc;
         case (state)
            S_IDLE: if (accept) state <= S_RUN;
            S_RUN: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31) state <= S_FETCH;
            end
            S_FETCH: if (i_ibus_cyc) state <= S_RESP; // Fetch started.
            S_RESP: if (cyc_fall) state <= accept ? S_RUN : S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) op_q <= i_cmd.op;
      if (run) rd_q <= {i_rd, rd_q[XLEN-1:1]}; // LSB arrives first.
   end

   // Every window starts at bit 0.
   a_cnt_idle : assert property (
      @(posedge clk) disable iff (i_rst)
      !run |-> (cnt == 5'd0)
   );

endmodule

// ==== serv_ctrl.sv ====
`timescale 1ns/1ns

module serv_ctrl import serv_pc_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = 32'd8
) (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_en,
   input  logic            i_pc_en,
   input  logic            i_cnt_done,
   input  logic            i_jump,
   input  logic            i_offset,
   input  logic            i_rs1,
   input  logic            i_jalr,
   input  logic            i_auipc,
   input  logic            i_lui,
   input  logic            i_trap,
   input  logic            i_csr_pc,
   output logic            o_rd,
   output logic            o_bad_pc,
   output logic            o_misalign,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   input  logic            i_ibus_ack
);

   logic pc;
   logic new_pc;
   logic pc_plus_4;
   logic plus_4;
   logic offset_a;
   logic pc_plus_offset;
   logic pc_plus_offset_aligned;

   logic en_r;
   logic en_2r;
   logic en_pc_r;
   logic en_pc_2r;
   logic en_pc_3r;

   // High only in the bit 2 cycle of the window.
   assign plus_4 = en_pc_2r & ~en_pc_3r;

   assign offset_a = i_jalr ? i_rs1 : pc; // Base.

   // en_pc_r is still low in the bit 0 cycle.
   assign pc_plus_offset_aligned = pc_plus_offset & en_pc_r;

   always_comb begin
      if (i_trap) begin
         new_pc = i_csr_pc & en_pc_r;
      end else if (i_jump) begin
         new_pc = pc_plus_offset_aligned;
      end else begin
         new_pc = pc_plus_4;
      end
   end

   always_comb begin
      if (i_lui) begin
         o_rd = i_offset;
      end else if (i_auipc) begin
         o_rd = pc_plus_offset_aligned;
      end else begin
         o_rd = pc_plus_4; // Link value.
      end
   end

   assign o_bad_pc      = pc_plus_offset_aligned;
   assign o_ibus_adr[0] = pc;

   ser_add u_add_plus_4 (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (pc),
      .i_b   (plus_4),
      .i_clr (i_cnt_done),
      .o_q   (pc_plus_4),
      .o_v   ()
   );

   ser_add u_add_target (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (offset_a),
      .i_b   (i_offset),
      .i_clr (i_cnt_done),
      .o_q   (pc_plus_offset),
      .o_v   ()
   );

   shift_reg #(
      .LEN  (XLEN),
      .INIT (RESET_PC)
   ) u_pc_reg (
      .clk      (clk),
      .i_en     (i_pc_en),
      .i_d      (new_pc),
      .i_load   (1'b0),
      .i_load_d ('0),
      .o_q      (pc),
      .o_par    (o_ibus_adr[XLEN-1:1])
   );

   always_ff @(posedge clk) begin
      if (i_rst) begin
         en_r       <= 1'b0;
         en_2r      <= 1'b0;
         en_pc_r    <= 1'b0;
         en_pc_2r   <= 1'b0;
         en_pc_3r   <= 1'b0;
         o_misalign <= 1'b0;
         o_ibus_cyc <= 1'b0;
      end else begin
         en_r     <= i_en;
         en_2r    <= en_r;
         en_pc_r  <= i_pc_en;
         en_pc_2r <= en_pc_r;
         en_pc_3r <= en_pc_2r;
         if (en_r & ~en_2r) begin
            o_misalign <= pc_plus_offset; // Bit 1 of base+offset.
         end
         if (en_pc_r & ~i_pc_en) begin
            o_ibus_cyc <= 1'b1; // Window closed, fetch new PC.
         end else if (o_ibus_cyc & i_ibus_ack) begin
            o_ibus_cyc <= 1'b0;
         end
      end
   end

   a_jump_trap : assert property (
      @(posedge clk) disable iff (i_rst)
      !(i_jump && i_trap)
   );

   a_cyc_pc_en : assert property (
      @(posedge clk) disable iff (i_rst)
      !(o_ibus_cyc && i_pc_en)
   );

endmodule

// ==== shift_reg.sv ====
`timescale 1ns/1ns

module shift_reg import serv_pc_pkg::*; #(
   parameter int             LEN  = XLEN,
   parameter logic [LEN-1:0] INIT = '0
) (
   input  logic           clk,
   input  logic           i_en,
   input  logic           i_d,
   input  logic           i_load,
   input  logic [LEN-1:0] i_load_d,
   output logic           o_q,
   output logic [LEN-2:0] o_par
);

   logic [LEN-1:0] data = INIT;

   always_ff @(posedge clk) begin
      if (i_load) begin
         data <= i_load_d; // Parallel load.
      end else if (i_en) begin
         data <= {i_d, data[LEN-1:1]}; // New bit in at the top.
      end
   end

   assign o_q   = data[0];
   assign o_par = data[LEN-1:1];

endmodule

// ==== ser_add.sv ====
`timescale 1ns/1ns

module ser_add (
   input  logic clk,
   input  logic i_rst,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q,
   output logic o_v
);

   logic c_r;
   logic c_next;

   assign o_q    = i_a ^ i_b ^ c_r;
   assign c_next = (i_a & i_b) | (i_a & c_r) | (i_b & c_r);

   // Carry into and out of the sign bit differ.
   assign o_v = c_next ^ c_r;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         c_r <= 1'b0;
      end else begin
         c_r <= c_next & ~i_clr; // Fresh word after clr.
      end
   end

   a_carry_clr : assert property (
      @(posedge clk) disable iff (i_rst)
      i_clr |=> !c_r
   );

endmodule

// ==== serv_pc_pkg.sv ====
package serv_pc_pkg;

   localparam int XLEN = 32;

   // Control-transfer command kinds.
   typedef enum logic [2:0] {
      OP_STEP  = 3'd0,
      OP_JAL   = 3'd1,
      OP_JALR  = 3'd2,
      OP_LUI   = 3'd3,
      OP_AUIPC = 3'd4,
      OP_TRAP  = 3'd5
   } ctrl_op_e;

   typedef struct packed {
      ctrl_op_e        op;
      logic [XLEN-1:0] offset; // Immediate.
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] csr_pc; // Trap vector.
   } ctrl_cmd_t;

   typedef struct packed {
      logic [XLEN-1:0] rd;
      logic            misalign;
   } ctrl_rsp_t;

endpackage
